// ==== rtl/line_pkg.sv ====
`default_nettype none

package line_pkg;

   // Width of one data half of a line
   localparam int HALF_W = 32;

   // Line occupancy 0 means all eight bytes are valid
   localparam logic [2:0] OCC_FULL = 3'd0;

   // Largest occupancy that still fits into one word
   localparam logic [2:0] HALF_OCC_MAX = 3'd4;

   // One 72-bit line item, MSB first
   typedef struct packed {
      logic [2:0]        spare;   // Always zero
      logic [2:0]        occ;     // Valid bytes on eof, 0 = all 8
      logic              eof;
      logic              sof;
      logic [HALF_W-1:0] hi;      // Data bits 63..32
      logic [HALF_W-1:0] lo;      // Data bits 31..0
   } line_t;

   // Full item width, 72
   localparam int LINE_W = $bits(line_t);

endpackage

`default_nettype wire

// ==== rtl/word_pkg.sv ====
`default_nettype none

package word_pkg;

   // Payload bits in one word
   localparam int WORD_DATA_W = 32;

   // Word occupancy 0 means all four bytes are valid
   localparam logic [1:0] WORD_OCC_FULL = 2'd0;

   // One 36-bit word item, MSB first
   typedef struct packed {
      logic [1:0]             occ;   // Nonzero only together with eof
      logic                   eof;
      logic                   sof;
      logic [WORD_DATA_W-1:0] data;
   } word_t;

   // Full item width, 36
   localparam int WORD_W = $bits(word_t);

endpackage

`default_nettype wire

// ==== rtl/fifo_short.sv ====
`timescale 1ns/100ps
`default_nettype none

module fifo_short #(
   parameter int WIDTH = 32
) (
   input  wire              clk,
   input  wire              reset,
   input  wire              clear_i,

   // Write side
   input  wire  [WIDTH-1:0] data_i,
   input  wire              src_rdy_i,
   output logic             dst_rdy_o,

   // Read side
   output logic [WIDTH-1:0] data_o,
   output logic             src_rdy_o,
   input  wire              dst_rdy_i
);

   localparam int DEPTH = 16;
   localparam int PTR_W = 4;

   // Count value with every entry taken
   localparam logic [PTR_W:0] FULL_COUNT = 5'd16;

   // Item storage
   logic [WIDTH-1:0] mem [DEPTH];

   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   logic [PTR_W:0]   count;
   logic             do_write;
   logic             do_read;

   // Ready flags straight from the count
   assign dst_rdy_o = (count != FULL_COUNT);
   assign src_rdy_o = (count != '0);

   // Transfers on each side
   assign do_write = src_rdy_i & dst_rdy_o;
   assign do_read  = src_rdy_o & dst_rdy_i;

   // Head entry is presented from the registered read pointer
   assign data_o = mem[rd_ptr];

   always_ff @(posedge clk) begin
      if (do_write) begin
         mem[wr_ptr] <= data_i;
      end
   end

   // Pointers wrap at 16 on their own
   always_ff @(posedge clk) begin
      if (reset || clear_i) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
      end else begin
         if (do_write) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (do_read) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
      end
   end

   // Occupancy count holds when both sides move together
   always_ff @(posedge clk) begin
      if (reset || clear_i) begin
         count <= '0;
      end else begin
         case ({do_write, do_read})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

endmodule

`default_nettype wire

// ==== rtl/line_splitter.sv ====
`timescale 1ns/100ps
`default_nettype none

module line_splitter #(
   parameter bit LE = 1'b0
) (
   input  wire                  clk,
   input  wire                  reset,
   input  wire                  clear_i,

   // Line side, from the head FIFO
   input  wire line_pkg::line_t line_i,
   input  wire                  line_src_rdy_i,
   output logic                 line_dst_rdy_o,

   // Word side, to the tail FIFO
   output word_pkg::word_t      word_o,
   output logic                 word_src_rdy_o,
   input  wire                  word_dst_rdy_i
);

   import line_pkg::*;
   import word_pkg::*;

   // 0 while the first word of a line is offered, 1 for the second
   logic phase;

   logic half_line;
   logic word_eof;
   logic word_xfer;
   logic line_xfer;

   // Last line of a frame with at most four bytes needs a single word
   assign half_line = line_i.eof &&
                      (line_i.occ != OCC_FULL) &&
                      (line_i.occ <= HALF_OCC_MAX);

   // First word ends the frame only for a half line
   assign word_eof = phase ? line_i.eof : half_line;

   // Word built from the current line and phase
   always_comb begin
      // LE picks the low half for the first word
      word_o.data = (LE ^ phase) ? line_i.lo : line_i.hi;
      // sof only on the first word
      word_o.sof  = phase ? 1'b0 : line_i.sof;
      word_o.eof  = word_eof;
      // Byte count carried on the closing word only
      word_o.occ  = word_eof ? line_i.occ[1:0] : WORD_OCC_FULL;
   end

   // A word is on offer whenever a line is present
   assign word_src_rdy_o = line_src_rdy_i;

   // Line retires together with its last word
   assign line_dst_rdy_o = (phase | half_line) & word_dst_rdy_i;

   assign word_xfer = word_src_rdy_o & word_dst_rdy_i;
   assign line_xfer = line_src_rdy_i & line_dst_rdy_o;

   always_ff @(posedge clk) begin
      if (reset || clear_i) begin
         phase <= 1'b0;
      end else if (line_xfer) begin
         // Back to the first half for the next line
         phase <= 1'b0;
      end else if (word_xfer) begin
         // First word of a full line went out
         phase <= 1'b1;
      end
   end

endmodule

`default_nettype wire

// ==== rtl/fifo72_to_fifo36.sv ====
`timescale 1ns/100ps
`default_nettype none

module fifo72_to_fifo36 #(
   parameter bit LE = 1'b0
) (
   input  wire                          clk,
   input  wire                          reset,
   input  wire                          clear_i,

   // 72-bit line input
   input  wire  [line_pkg::LINE_W-1:0]  f72_data_i,
   input  wire                          f72_src_rdy_i,
   output logic                         f72_dst_rdy_o,

   // 36-bit word output
   output logic [word_pkg::WORD_W-1:0]  f36_data_o,
   output logic                         f36_src_rdy_o,
   input  wire                          f36_dst_rdy_i
);

   import line_pkg::*;
   import word_pkg::*;

   // Head FIFO to splitter
   line_t head_line;
   logic  head_src_rdy;
   logic  head_dst_rdy;

   // Splitter to tail FIFO
   word_t split_word;
   logic  split_src_rdy;
   logic  split_dst_rdy;

   // Input buffer, decouples the line handshake
   fifo_short #(.WIDTH(LINE_W)) head_fifo (
      .clk       (clk),
      .reset     (reset),
      .clear_i   (clear_i),
      .data_i    (f72_data_i),
      .src_rdy_i (f72_src_rdy_i),
      .dst_rdy_o (f72_dst_rdy_o),
      .data_o    (head_line),
      .src_rdy_o (head_src_rdy),
      .dst_rdy_i (head_dst_rdy)
   );

   line_splitter #(.LE(LE)) u_splitter (
      .clk            (clk),
      .reset          (reset),
      .clear_i        (clear_i),
      .line_i         (head_line),
      .line_src_rdy_i (head_src_rdy),
      .line_dst_rdy_o (head_dst_rdy),
      .word_o         (split_word),
      .word_src_rdy_o (split_src_rdy),
      .word_dst_rdy_i (split_dst_rdy)
   );

   // Output buffer, absorbs word back-pressure
   fifo_short #(.WIDTH(WORD_W)) tail_fifo (
      .clk       (clk),
      .reset     (reset),
      .clear_i   (clear_i),
      .data_i    (split_word),
      .src_rdy_i (split_src_rdy),
      .dst_rdy_o (split_dst_rdy),
      .data_o    (f36_data_o),
      .src_rdy_o (f36_src_rdy_o),
      .dst_rdy_i (f36_dst_rdy_i)
   );

endmodule

`default_nettype wire

// ==== tb/fifo72_to_fifo36_asserts.sv ====
`timescale 1ns/100ps
`default_nettype none

module fifo72_to_fifo36_asserts (
   input wire                        clk,
   input wire                        reset,
   input wire                        clear_i,
   input wire                        f72_dst_rdy_o,
   input wire [word_pkg::WORD_W-1:0] f36_data_o,
   input wire                        f36_src_rdy_o,
   input wire                        f36_dst_rdy_i
);

   import word_pkg::*;

   // Output word split into its fields
   word_t f36_word;

   // Failure count of each property
   int hold_fails  = 0;
   int ready_fails = 0;
   int occ_fails   = 0;
   int fail_total;

   assign f36_word   = f36_data_o;
   assign fail_total = hold_fails + ready_fails + occ_fails;

   // Stalled word keeps its value unless a clear empties the FIFO
   f36_hold: assert property (@(posedge clk) disable iff (reset)
      (f36_src_rdy_o && !f36_dst_rdy_i && !clear_i) |=>
      (f36_src_rdy_o && $stable(f36_data_o)))
   else begin
      $error("f36 word changed or vanished while stalled");
      hold_fails++;
   end

   // Empty head FIFO right after reset
   f72_ready_after_reset: assert property (@(posedge clk) reset |=> f72_dst_rdy_o)
   else begin
      $error("f72 ready low in the cycle after reset");
      ready_fails++;
   end

   // Byte count only on a closing word
   f36_occ_needs_eof: assert property (@(posedge clk) disable iff (reset)
      (f36_src_rdy_o && f36_word.sof && (f36_word.occ != 2'd0)) |-> f36_word.eof)
   else begin
      $error("f36 word with sof and nonzero occ but no eof");
      occ_fails++;
   end

endmodule

`default_nettype wire

// ==== tb/tb_fifo72_to_fifo36.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_fifo72_to_fifo36;

   import line_pkg::*;
   import word_pkg::*;

   localparam int NUM_ROWS       = 54;
   localparam int TIMEOUT_CYCLES = 40 * NUM_ROWS + 200;
   localparam int PAT_LEN        = 256;

   // Row groups, each with its own output behavior
   localparam logic [1:0] GRP_READY    = 2'd0;
   localparam logic [1:0] GRP_STALL    = 2'd1;
   localparam logic [1:0] GRP_PRE_CLR  = 2'd2;
   localparam logic [1:0] GRP_POST_CLR = 2'd3;

   // f36 ready modes
   localparam int MODE_READY  = 0;
   localparam int MODE_RANDOM = 1;
   localparam int MODE_HOLD   = 2;

   logic clk = 1'b0;
   logic reset;
   logic clear_i;
   logic [LINE_W-1:0] f72_data_i;
   logic f72_src_rdy_i;
   logic f36_dst_rdy_i = 1'b0;

   logic f72_dst_rdy_o;
   logic [WORD_W-1:0] f36_data_o;
   logic f36_src_rdy_o;
   logic le_f72_dst_rdy_o;
   logic [WORD_W-1:0] le_f36_data_o;
   logic le_f36_src_rdy_o;

   // Stimulus table, one line per row
   string       tab_name [NUM_ROWS];
   logic [1:0]  tab_grp  [NUM_ROWS];
   logic [31:0] tab_hi   [NUM_ROWS];
   logic [31:0] tab_lo   [NUM_ROWS];
   logic        tab_sof  [NUM_ROWS];
   logic        tab_eof  [NUM_ROWS];
   logic [2:0]  tab_occ  [NUM_ROWS];
   int          n_rows = 0;

   // Expected words per instance, in arrival order
   logic [WORD_W-1:0] exp0_q [$];
   logic [WORD_W-1:0] exp1_q [$];
   string             name0_q [$];
   string             name1_q [$];

   integer     seed = 82;
   bit         ready_pat [PAT_LEN];
   logic [7:0] pat_idx = '0;
   int         out_mode = MODE_READY;
   int         cycle_count = 0;
   int         mon_errors = 0;
   int         flow_errors = 0;
   int         assert_fails;
   logic       saw_backpressure = 1'b0;

   fifo72_to_fifo36 #(.LE(1'b0)) i_dut (
      .clk           (clk),
      .reset         (reset),
      .clear_i       (clear_i),
      .f72_data_i    (f72_data_i),
      .f72_src_rdy_i (f72_src_rdy_i),
      .f72_dst_rdy_o (f72_dst_rdy_o),
      .f36_data_o    (f36_data_o),
      .f36_src_rdy_o (f36_src_rdy_o),
      .f36_dst_rdy_i (f36_dst_rdy_i)
   );

   // Low half first, same stimulus
   fifo72_to_fifo36 #(.LE(1'b1)) i_dut_le (
      .clk           (clk),
      .reset         (reset),
      .clear_i       (clear_i),
      .f72_data_i    (f72_data_i),
      .f72_src_rdy_i (f72_src_rdy_i),
      .f72_dst_rdy_o (le_f72_dst_rdy_o),
      .f36_data_o    (le_f36_data_o),
      .f36_src_rdy_o (le_f36_src_rdy_o),
      .f36_dst_rdy_i (f36_dst_rdy_i)
   );

   bind fifo72_to_fifo36 fifo72_to_fifo36_asserts i_asserts (
      .clk           (clk),
      .reset         (reset),
      .clear_i       (clear_i),
      .f72_dst_rdy_o (f72_dst_rdy_o),
      .f36_data_o    (f36_data_o),
      .f36_src_rdy_o (f36_src_rdy_o),
      .f36_dst_rdy_i (f36_dst_rdy_i)
   );

   always #10 clk = ~clk;

   task automatic add_row(input string name, input logic [1:0] grp, input logic [31:0] hi,
                          input logic [31:0] lo, input logic sof, input logic eof,
                          input logic [2:0] occ);
      tab_name[n_rows] = name;
      tab_grp[n_rows]  = grp;
      tab_hi[n_rows]   = hi;
      tab_lo[n_rows]   = lo;
      tab_sof[n_rows]  = sof;
      tab_eof[n_rows]  = eof;
      tab_occ[n_rows]  = occ;
      n_rows++;
   endtask

   task automatic fill_table();
      logic [31:0] rnd_hi;
      logic [31:0] rnd_lo;
      logic [31:0] rnd_occ;
      // Single lines, then one four-line frame ending in a half line
      add_row("full_mid",  GRP_READY, 32'h1111_2222, 32'h3333_4444, 1'b1, 1'b0, 3'd0);
      add_row("full_eof0", GRP_READY, 32'h5555_6666, 32'h7777_8888, 1'b0, 1'b1, 3'd0);
      add_row("half_occ1", GRP_READY, 32'hA1A2_A3A4, 32'hB1B2_B3B4, 1'b1, 1'b1, 3'd1);
      add_row("half_occ4", GRP_READY, 32'hC1C2_C3C4, 32'hD1D2_D3D4, 1'b1, 1'b1, 3'd4);
      add_row("full_occ5", GRP_READY, 32'hE1E2_E3E4, 32'hF1F2_F3F4, 1'b1, 1'b1, 3'd5);
      add_row("full_occ7", GRP_READY, 32'h0102_0304, 32'h0506_0708, 1'b1, 1'b1, 3'd7);
      add_row("frame_a0",  GRP_READY, 32'h2000_0001, 32'h2000_0002, 1'b1, 1'b0, 3'd0);
      add_row("frame_a1",  GRP_READY, 32'h2000_0003, 32'h2000_0004, 1'b0, 1'b0, 3'd0);
      add_row("frame_a2",  GRP_READY, 32'h2000_0005, 32'h2000_0006, 1'b0, 1'b0, 3'd0);
      add_row("frame_a3",  GRP_READY, 32'h2000_0007, 32'h2000_0008, 1'b0, 1'b1, 3'd3);
      // Random four-line frames for the stall phase
      for (int k = 0; k < 32; k++) begin
         rnd_hi  = $random(seed);
         rnd_lo  = $random(seed);
         rnd_occ = $random(seed);
         add_row($sformatf("stall_%0d", k), GRP_STALL, rnd_hi, rnd_lo, (k % 4) == 0,
                 (k % 4) == 3, ((k % 4) == 3) ? rnd_occ[2:0] : 3'd0);
      end
      // Seven full lines and a half line fill the tail FIFO to 15 words,
      // the next line then leaves the splitter in phase 1
      for (int k = 0; k < 7; k++) begin
         add_row($sformatf("pre_clr_%0d", k), GRP_PRE_CLR, 32'hC1EA_0000 + k,
                 32'hC1EA_1000 + k, k == 0, 1'b0, 3'd0);
      end
      add_row("pre_clr_end",  GRP_PRE_CLR, 32'hC1EA_00EE, 32'hC1EA_10EE, 1'b0, 1'b1, 3'd2);
      add_row("pre_clr_next", GRP_PRE_CLR, 32'hC1EA_00FF, 32'hC1EA_10FF, 1'b1, 1'b0, 3'd0);
      add_row("post_sof", GRP_POST_CLR, 32'h9000_0A0A, 32'h9000_0B0B, 1'b1, 1'b0, 3'd0);
      add_row("post_mid", GRP_POST_CLR, 32'h9000_0C0C, 32'h9000_0D0D, 1'b0, 1'b0, 3'd0);
      add_row("post_end", GRP_POST_CLR, 32'h9000_0E0E, 32'h9000_0F0F, 1'b0, 1'b1, 3'd6);
      // Output ready about one cycle in eight while stalling
      for (int k = 0; k < PAT_LEN; k++) begin
         rnd_hi = $random(seed);
         ready_pat[k] = (rnd_hi[2:0] == 3'd0);
      end
   endtask

   // Reference words for one line, for both half orders
   task automatic expand_row(input int idx);
      logic  half;
      word_t w;
      half   = tab_eof[idx] && (tab_occ[idx] >= 3'd1) && (tab_occ[idx] <= 3'd4);
      w.sof  = tab_sof[idx];
      w.eof  = half;
      w.occ  = half ? tab_occ[idx][1:0] : 2'd0;
      w.data = tab_hi[idx];
      exp0_q.push_back(w);
      name0_q.push_back(tab_name[idx]);
      w.data = tab_lo[idx];
      exp1_q.push_back(w);
      name1_q.push_back(tab_name[idx]);
      if (!half) begin
         // Second word closes the line
         w.sof  = 1'b0;
         w.eof  = tab_eof[idx];
         w.occ  = tab_eof[idx] ? tab_occ[idx][1:0] : 2'd0;
         w.data = tab_lo[idx];
         exp0_q.push_back(w);
         name0_q.push_back(tab_name[idx]);
         w.data = tab_hi[idx];
         exp1_q.push_back(w);
         name1_q.push_back(tab_name[idx]);
      end
   endtask

   task automatic push_line(input int idx);
      line_t ln;
      logic  accepted;
      ln.spare = 3'b000;
      ln.occ   = tab_occ[idx];
      ln.eof   = tab_eof[idx];
      ln.sof   = tab_sof[idx];
      ln.hi    = tab_hi[idx];
      ln.lo    = tab_lo[idx];
      accepted = 1'b0;
      // Hold the line until the head FIFO takes it
      while (!accepted) begin
         @(negedge clk);
         f72_data_i    = ln;
         f72_src_rdy_i = 1'b1;
         if (f72_dst_rdy_o) begin
            accepted = 1'b1;
            expand_row(idx);
         end
      end
   endtask

   task automatic idle_input();
      @(negedge clk);
      f72_src_rdy_i = 1'b0;
      f72_data_i    = '0;
   endtask

   task automatic set_mode(input int mode);
      @(posedge clk);
      out_mode = mode;
   endtask

   task automatic wait_drain();
      while (exp0_q.size() != 0 || exp1_q.size() != 0) begin
         @(negedge clk);
      end
   endtask

   task automatic pulse_clear();
      @(negedge clk);
      if (!f36_src_rdy_o || !le_f36_src_rdy_o) begin
         $display("Error: no words were waiting at f36 before the clear");
         flow_errors++;
      end
      clear_i = 1'b1;
      // Nothing from before the clear may come out
      exp0_q.delete();
      exp1_q.delete();
      name0_q.delete();
      name1_q.delete();
      @(negedge clk);
      clear_i = 1'b0;
      if (f36_src_rdy_o || le_f36_src_rdy_o) begin
         $display("Error: f36 source ready still high in the cycle after the clear");
         flow_errors++;
      end
   endtask

   task automatic enter_group(input logic [1:0] grp);
      idle_input();
      case (grp)
         GRP_STALL: begin
            wait_drain();
            set_mode(MODE_RANDOM);
         end
         GRP_PRE_CLR: begin
            wait_drain();
            if (!saw_backpressure) begin
               $display("Error: f72 ready never dropped during the output stalls");
               flow_errors++;
            end
            set_mode(MODE_HOLD);
         end
         GRP_POST_CLR: begin
            // Let the splitter run into the full tail FIFO
            repeat (20) @(negedge clk);
            pulse_clear();
            set_mode(MODE_READY);
         end
         default: begin
         end
      endcase
   endtask

   task automatic check_word(input bit le, input logic [WORD_W-1:0] actual);
      logic [WORD_W-1:0] expected;
      string             name;
      if ((le ? exp1_q.size() : exp0_q.size()) == 0) begin
         $display("Error: instance with LE %0d sent word %h when none was expected",
                  le, actual);
         mon_errors++;
      end else begin
         if (le) begin
            expected = exp1_q.pop_front();
            name     = name1_q.pop_front();
         end else begin
            expected = exp0_q.pop_front();
            name     = name0_q.pop_front();
         end
         if (actual !== expected) begin
            $display("FAIL %s (LE %0d): expected %h, actual %h", name, le, expected, actual);
            mon_errors++;
         end
      end
   endtask

   // f36 ready, driven on the falling edge
   always @(negedge clk) begin
      case (out_mode)
         MODE_READY:  f36_dst_rdy_i = 1'b1;
         MODE_RANDOM: f36_dst_rdy_i = ready_pat[pat_idx];
         default:     f36_dst_rdy_i = 1'b0;
      endcase
      pat_idx = pat_idx + 1'b1;
   end

   // Compare every f36 transfer with the reference queues
   always @(posedge clk) begin
      if (!reset) begin
         if (!f72_dst_rdy_o) begin
            saw_backpressure = 1'b1;
         end
         if (f72_dst_rdy_o !== le_f72_dst_rdy_o) begin
            $display("Error: the two instances disagree on f72 ready");
            mon_errors++;
         end
         if (f36_src_rdy_o && f36_dst_rdy_i) begin
            check_word(1'b0, f36_data_o);
         end
         if (le_f36_src_rdy_o && f36_dst_rdy_i) begin
            check_word(1'b1, le_f36_data_o);
         end
      end
   end

   always @(posedge clk) begin
      cycle_count++;
      if (cycle_count >= TIMEOUT_CYCLES) begin
         $display("Error: timeout after %0d cycles, words still missing", cycle_count);
         $display("SOME TESTS FAILED");
         $finish;
      end
   end

   initial begin
      reset         = 1'b1;
      clear_i       = 1'b0;
      f72_data_i    = '0;
      f72_src_rdy_i = 1'b0;
      fill_table();
      repeat (4) @(posedge clk);
      @(negedge clk);
      reset = 1'b0;
      for (int i = 0; i < n_rows; i++) begin
         if (i > 0 && tab_grp[i] != tab_grp[i-1]) begin
            enter_group(tab_grp[i]);
         end
         push_line(i);
      end
      idle_input();
      wait_drain();
      // Any late extra word shows up here
      repeat (10) @(negedge clk);
      assert_fails = i_dut.i_asserts.fail_total + i_dut_le.i_asserts.fail_total;
      $display("Done: %0d check errors, %0d flow errors, %0d assertion failures",
               mon_errors, flow_errors, assert_fails);
      if (mon_errors == 0 && flow_errors == 0 && assert_fails == 0) begin
         $display("ALL TESTS PASSED");
      end else begin
         $display("SOME TESTS FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== sim.f ====
rtl/line_pkg.sv
rtl/word_pkg.sv
rtl/fifo_short.sv
rtl/line_splitter.sv
rtl/fifo72_to_fifo36.sv
tb/fifo72_to_fifo36_asserts.sv
tb/tb_fifo72_to_fifo36.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build with Verilator, run, and judge the result from the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log
verilator --binary --timing --assert -j 0 -f sim.f \
   --top-module tb_fifo72_to_fifo36 -o sim_tb > build.log 2>&1 \
   || { cat build.log; echo "Build failed"; exit 1; }
./obj_dir/sim_tb +verilator+error+limit+100 > sim.log 2>&1
cat sim.log
grep -q "ALL TESTS PASSED" sim.log && echo "Simulation passed" \
   || { echo "Simulation failed"; exit 1; }
